// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := peri_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv) $(wildcard verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/com_fifo.sv
// Synchronous circular FIFO with occupancy count for the communication pipes
`default_nettype none

module com_fifo (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   push_i,
    input  logic [peri_bus_pkg::WB_DAT_WIDTH-1:0]  push_dat_i,
    input  logic                                   pop_i,
    output logic [peri_bus_pkg::WB_DAT_WIDTH-1:0]  pop_dat_o,
    output logic                                   empty_o,
    output logic                                   full_o,
    output logic [peri_map_pkg::COM_PTR_WIDTH:0]   count_o
);

    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] mem [peri_map_pkg::COM_FIFO_DEPTH];
    logic [peri_map_pkg::COM_PTR_WIDTH-1:0] wr_ptr;
    logic [peri_map_pkg::COM_PTR_WIDTH-1:0] rd_ptr;
    logic [peri_map_pkg::COM_PTR_WIDTH:0]   count;
    logic                                   do_push;
    logic                                   do_pop;

    assign do_push = push_i && !full_o;     // Dropped when full
    assign do_pop  = pop_i && !empty_o;     // No pop when empty

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_dat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign pop_dat_o = mem[rd_ptr];
    assign empty_o   = (count == '0);
    assign full_o    = count[peri_map_pkg::COM_PTR_WIDTH];  // Count equals depth
    assign count_o   = count;

endmodule

`default_nettype wire

// File: design/com_pipe.sv
// Communication pipe around one bus-mapped FIFO with status and interrupt enables
`default_nettype none

module com_pipe (
    input  logic      clk_i,
    input  logic      rst_i,
    wb_peri_if.slave  bus_i,
    output logic      irq_rx_o,
    output logic      irq_tx_o
);

    logic [peri_map_pkg::REG_OFS_WIDTH-1:0] reg_ofs;
    logic                                   bus_wr;
    logic                                   bus_rd;
    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0]  fifo_dat;
    logic                                   fifo_empty;
    logic                                   fifo_full;
    logic [peri_map_pkg::COM_PTR_WIDTH:0]   fifo_count;
    logic                                   tx_en;
    logic                                   rx_en;

    assign reg_ofs = bus_i.adr[peri_map_pkg::REG_OFS_WIDTH-1:0];
    assign bus_wr  = bus_i.stb && bus_i.we;
    assign bus_rd  = bus_i.stb && !bus_i.we;

    // --------------------------------------------------
    // Buffer
    // --------------------------------------------------

    com_fifo i_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (bus_wr && (reg_ofs == peri_map_pkg::COM_REG_DATA)),
        .push_dat_i (bus_i.dat_w),
        .pop_i      (bus_rd && (reg_ofs == peri_map_pkg::COM_REG_DATA)),
        .pop_dat_o  (fifo_dat),
        .empty_o    (fifo_empty),
        .full_o     (fifo_full),
        .count_o    (fifo_count)
    );

    // Interrupt enables
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en <= 1'b0;
            rx_en <= 1'b0;
        end else if (bus_wr && (reg_ofs == peri_map_pkg::COM_REG_IRQEN)) begin
            tx_en <= bus_i.dat_w[0];
            rx_en <= bus_i.dat_w[1];
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    always_comb begin
        bus_i.dat_r = '0;
        case (reg_ofs)
            peri_map_pkg::COM_REG_DATA: begin
                if (!fifo_empty) begin
                    bus_i.dat_r = fifo_dat;     // Head word
                end
            end
            peri_map_pkg::COM_REG_STATUS: begin
                bus_i.dat_r[peri_map_pkg::COM_PTR_WIDTH:0]      = fifo_count;
                bus_i.dat_r[peri_map_pkg::COM_STAT_FULL_BIT]  = fifo_full;
                bus_i.dat_r[peri_map_pkg::COM_STAT_EMPTY_BIT] = fifo_empty;
            end
            peri_map_pkg::COM_REG_IRQEN: begin
                bus_i.dat_r[1:0] = {rx_en, tx_en};
            end
            default: begin
                bus_i.dat_r = '0;
            end
        endcase
    end

    assign bus_i.ack = bus_i.stb;

    // Level interrupts from registered state
    assign irq_rx_o = rx_en && !fifo_empty;
    assign irq_tx_o = tx_en && !fifo_full;

endmodule

`default_nettype wire

// File: design/interval_timer.sv
// Interval timer with compare match and sticky interrupt
`default_nettype none

module interval_timer (
    input  logic      clk_i,
    input  logic      rst_i,
    wb_peri_if.slave  bus_i,
    output logic      irq_o
);

    logic [peri_map_pkg::REG_OFS_WIDTH-1:0] reg_ofs;
    logic                                   bus_wr;
    logic                                   enable;
    logic [peri_map_pkg::TIM_CNT_WIDTH-1:0] cmp;
    logic [peri_map_pkg::TIM_CNT_WIDTH-1:0] cnt;
    logic                                   irq_flag;
    logic                                   match;

    assign reg_ofs = bus_i.adr[peri_map_pkg::REG_OFS_WIDTH-1:0];
    assign bus_wr  = bus_i.stb && bus_i.we;
    assign match   = enable && (cnt == cmp);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable   <= 1'b0;
            cmp      <= '0;
            cnt      <= '0;
            irq_flag <= 1'b0;
        end else begin
            if (bus_wr && (reg_ofs == peri_map_pkg::TIM_REG_CTL)) begin
                enable <= bus_i.dat_w[0];
            end
            if (bus_wr && (reg_ofs == peri_map_pkg::TIM_REG_CMP)) begin
                cmp <= bus_i.dat_w[peri_map_pkg::TIM_CNT_WIDTH-1:0];
            end

            // Count and wrap at compare
            if (match) begin
                cnt <= '0;
            end else if (enable) begin
                cnt <= cnt + 1'b1;
            end

            // A new match wins over a write one to clear
            if (match) begin
                irq_flag <= 1'b1;
            end else if (bus_wr && (reg_ofs == peri_map_pkg::TIM_REG_STAT)
                         && bus_i.dat_w[0]) begin
                irq_flag <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Register read
    // --------------------------------------------------

    always_comb begin
        bus_i.dat_r = '0;
        case (reg_ofs)
            peri_map_pkg::TIM_REG_CTL:  bus_i.dat_r[0] = enable;
            peri_map_pkg::TIM_REG_CMP:  bus_i.dat_r = peri_bus_pkg::WB_DAT_WIDTH'(cmp);
            peri_map_pkg::TIM_REG_CNT:  bus_i.dat_r = peri_bus_pkg::WB_DAT_WIDTH'(cnt);
            peri_map_pkg::TIM_REG_STAT: bus_i.dat_r[0] = irq_flag;
            default:                    bus_i.dat_r = '0;
        endcase
    end

    assign bus_i.ack = bus_i.stb;
    assign irq_o     = irq_flag;

endmodule

`default_nettype wire

// File: design/led_ctrl.sv
// LED control with a bus-writable LED bit and a free-running heartbeat
`default_nettype none

module led_ctrl (
    input  logic        clk_i,
    input  logic        rst_i,
    wb_peri_if.slave    bus_i,
    output logic [1:0]  led_o
);

    logic                                 led_bit;
    logic [peri_map_pkg::HEARTBEAT_BIT:0] beat_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_bit <= 1'b0;
        end else if (bus_i.stb && bus_i.we && bus_i.sel[0]) begin
            led_bit <= bus_i.dat_w[0];
        end
    end

    // Heartbeat counter starts at zero after reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign bus_i.dat_r = peri_bus_pkg::WB_DAT_WIDTH'(led_bit);
    assign bus_i.ack   = bus_i.stb;

    assign led_o[0] = led_bit;
    assign led_o[1] = beat_cnt[peri_map_pkg::HEARTBEAT_BIT];

endmodule

`default_nettype wire

// File: design/peri_bus_pkg.sv
// Peripheral bus package with Wishbone geometry and address region codes
`default_nettype none

package peri_bus_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------

    localparam int WB_ADR_WIDTH = 24;                 // Word address
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;   // One select per byte

    // --------------------------------------------------
    // Region select
    // --------------------------------------------------

    localparam int REGION_MSB = 23;
    localparam int REGION_LSB = 16;

    localparam logic [REGION_MSB-REGION_LSB:0] REGION_COM0 = 8'h01;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_COM1 = 8'h02;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_TIM  = 8'h08;
    localparam logic [REGION_MSB-REGION_LSB:0] REGION_LED  = 8'h11;

endpackage

`default_nettype wire

// File: design/peri_map_pkg.sv
// Peripheral register map package with offsets, sizes and interrupt positions
`default_nettype none

package peri_map_pkg;

    // Register offset field in the low word address bits
    localparam int REG_OFS_WIDTH = 2;

    // --------------------------------------------------
    // Communication pipe
    // --------------------------------------------------

    localparam logic [REG_OFS_WIDTH-1:0] COM_REG_DATA   = 2'd0;
    localparam logic [REG_OFS_WIDTH-1:0] COM_REG_STATUS = 2'd1;
    localparam logic [REG_OFS_WIDTH-1:0] COM_REG_IRQEN  = 2'd2;

    localparam int COM_PTR_WIDTH  = 4;
    localparam int COM_FIFO_DEPTH = 1 << COM_PTR_WIDTH;

    localparam int COM_STAT_FULL_BIT  = 8;
    localparam int COM_STAT_EMPTY_BIT = 9;

    // --------------------------------------------------
    // Interval timer
    // --------------------------------------------------

    localparam logic [REG_OFS_WIDTH-1:0] TIM_REG_CTL  = 2'd0;
    localparam logic [REG_OFS_WIDTH-1:0] TIM_REG_CMP  = 2'd1;
    localparam logic [REG_OFS_WIDTH-1:0] TIM_REG_CNT  = 2'd2;
    localparam logic [REG_OFS_WIDTH-1:0] TIM_REG_STAT = 2'd3;

    localparam int TIM_CNT_WIDTH = 32;

    localparam int HEARTBEAT_BIT = 9;   // 1024 cycle period

    // Interrupt vector layout
    localparam int IRQ_NUM     = 5;
    localparam int IRQ_COM0_RX = 0;
    localparam int IRQ_COM0_TX = 1;
    localparam int IRQ_COM1_RX = 2;
    localparam int IRQ_COM1_TX = 3;
    localparam int IRQ_TIM     = 4;

endpackage

`default_nettype wire

// File: design/peri_top.sv
// Peripheral subsystem top level that wires the Wishbone decoder to the peripherals
`default_nettype none

module peri_top (
    input  logic                                   wb_peri_clk_i,
    input  logic                                   wb_peri_rst_i,
    input  logic [peri_bus_pkg::WB_ADR_WIDTH-1:0]  wb_peri_adr_i,
    input  logic [peri_bus_pkg::WB_DAT_WIDTH-1:0]  wb_peri_dat_i,
    input  logic                                   wb_peri_we_i,
    input  logic [peri_bus_pkg::WB_SEL_WIDTH-1:0]  wb_peri_sel_i,
    input  logic                                   wb_peri_stb_i,
    output logic [peri_bus_pkg::WB_DAT_WIDTH-1:0]  wb_peri_dat_o,
    output logic                                   wb_peri_ack_o,
    output logic [1:0]                             led_o,
    output logic [peri_map_pkg::IRQ_NUM-1:0]       irq_o
);

    wb_peri_if com0_bus ();
    wb_peri_if com1_bus ();
    wb_peri_if tim_bus ();
    wb_peri_if led_bus ();

    logic com0_irq_rx;
    logic com0_irq_tx;
    logic com1_irq_rx;
    logic com1_irq_tx;
    logic tim_irq;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    wb_addr_decode i_decode (
        .adr_i  (wb_peri_adr_i),
        .dat_i  (wb_peri_dat_i),
        .we_i   (wb_peri_we_i),
        .sel_i  (wb_peri_sel_i),
        .stb_i  (wb_peri_stb_i),
        .dat_o  (wb_peri_dat_o),
        .ack_o  (wb_peri_ack_o),
        .com0_o (com0_bus),
        .com1_o (com1_bus),
        .tim_o  (tim_bus),
        .led_o  (led_bus)
    );

    // --------------------------------------------------
    // Peripherals
    // --------------------------------------------------

    com_pipe i_com0 (
        .clk_i    (wb_peri_clk_i),
        .rst_i    (wb_peri_rst_i),
        .bus_i    (com0_bus),
        .irq_rx_o (com0_irq_rx),
        .irq_tx_o (com0_irq_tx)
    );

    com_pipe i_com1 (
        .clk_i    (wb_peri_clk_i),
        .rst_i    (wb_peri_rst_i),
        .bus_i    (com1_bus),
        .irq_rx_o (com1_irq_rx),
        .irq_tx_o (com1_irq_tx)
    );

    interval_timer i_timer (
        .clk_i (wb_peri_clk_i),
        .rst_i (wb_peri_rst_i),
        .bus_i (tim_bus),
        .irq_o (tim_irq)
    );

    led_ctrl i_led (
        .clk_i (wb_peri_clk_i),
        .rst_i (wb_peri_rst_i),
        .bus_i (led_bus),
        .led_o (led_o)
    );

    // Interrupt vector
    always_comb begin
        irq_o = '0;
        irq_o[peri_map_pkg::IRQ_COM0_RX] = com0_irq_rx;
        irq_o[peri_map_pkg::IRQ_COM0_TX] = com0_irq_tx;
        irq_o[peri_map_pkg::IRQ_COM1_RX] = com1_irq_rx;
        irq_o[peri_map_pkg::IRQ_COM1_TX] = com1_irq_tx;
        irq_o[peri_map_pkg::IRQ_TIM]     = tim_irq;
    end

endmodule

`default_nettype wire

// File: design/wb_addr_decode.sv
// Address decoder that splits the peripheral bus into regions and muxes the replies
`default_nettype none

module wb_addr_decode (
    input  logic [peri_bus_pkg::WB_ADR_WIDTH-1:0] adr_i,
    input  logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_i,
    input  logic                                  we_i,
    input  logic [peri_bus_pkg::WB_SEL_WIDTH-1:0] sel_i,
    input  logic                                  stb_i,
    output logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_o,
    output logic                                  ack_o,
    wb_peri_if.master                             com0_o,
    wb_peri_if.master                             com1_o,
    wb_peri_if.master                             tim_o,
    wb_peri_if.master                             led_o
);

    logic [peri_bus_pkg::REGION_MSB-peri_bus_pkg::REGION_LSB:0] region;

    assign region = adr_i[peri_bus_pkg::REGION_MSB:peri_bus_pkg::REGION_LSB];

    // --------------------------------------------------
    // Strobe per region
    // --------------------------------------------------

    assign com0_o.stb = stb_i && (region == peri_bus_pkg::REGION_COM0);
    assign com1_o.stb = stb_i && (region == peri_bus_pkg::REGION_COM1);
    assign tim_o.stb  = stb_i && (region == peri_bus_pkg::REGION_TIM);
    assign led_o.stb  = stb_i && (region == peri_bus_pkg::REGION_LED);

    // Shared request fields
    assign com0_o.adr   = adr_i;
    assign com0_o.dat_w = dat_i;
    assign com0_o.we    = we_i;
    assign com0_o.sel   = sel_i;

    assign com1_o.adr   = adr_i;
    assign com1_o.dat_w = dat_i;
    assign com1_o.we    = we_i;
    assign com1_o.sel   = sel_i;

    assign tim_o.adr    = adr_i;
    assign tim_o.dat_w  = dat_i;
    assign tim_o.we     = we_i;
    assign tim_o.sel    = sel_i;

    assign led_o.adr    = adr_i;
    assign led_o.dat_w  = dat_i;
    assign led_o.we     = we_i;
    assign led_o.sel    = sel_i;

    // --------------------------------------------------
    // Reply mux
    // --------------------------------------------------

    always_comb begin
        dat_o = '0;
        ack_o = stb_i;      // Unmapped regions ack at once with zero data
        if (com0_o.stb) begin
            dat_o = com0_o.dat_r;
            ack_o = com0_o.ack;
        end else if (com1_o.stb) begin
            dat_o = com1_o.dat_r;
            ack_o = com1_o.ack;
        end else if (tim_o.stb) begin
            dat_o = tim_o.dat_r;
            ack_o = tim_o.ack;
        end else if (led_o.stb) begin
            dat_o = led_o.dat_r;
            ack_o = led_o.ack;
        end
    end

endmodule

`default_nettype wire

// File: design/wb_peri_if.sv
// Wishbone classic slave-side link between the decoder and one peripheral
`default_nettype none

interface wb_peri_if;

    logic [peri_bus_pkg::WB_ADR_WIDTH-1:0] adr;
    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_w;
    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_r;
    logic                                  we;
    logic [peri_bus_pkg::WB_SEL_WIDTH-1:0] sel;
    logic                                  stb;
    logic                                  ack;

    // Decoder side
    modport master (
        output adr, dat_w, we, sel, stb,
        input  dat_r, ack
    );

    // Peripheral side
    modport slave (
        input  adr, dat_w, we, sel, stb,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: project.f
design/peri_bus_pkg.sv
design/peri_map_pkg.sv
design/wb_peri_if.sv
design/wb_addr_decode.sv
design/com_fifo.sv
design/com_pipe.sv
design/interval_timer.sv
design/led_ctrl.sv
design/peri_top.sv
verif/peri_asserts.sv
verif/peri_tb.sv

// File: verif/peri_asserts.sv
// Bus protocol checks on the address decoder, bound in from the testbench
`default_nettype none

module peri_asserts (
    input  logic                                  clk_i,
    input  logic                                  stb_i,
    input  logic                                  ack_i,
    input  logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_i,
    input  logic [3:0]                            region_stb_i   // com0, com1, tim, led
);

    int fail_cnt = 0;   // Watched by the testbench

    // --------------------------------------------------
    // Decoder properties
    // --------------------------------------------------

    a_one_region: assert property (@(posedge clk_i) $onehot0(region_stb_i))
        else begin
            $error("more than one peripheral strobe is high");
            fail_cnt++;
        end

    // Every slave answers in the strobe cycle
    a_ack_follows_stb: assert property (@(posedge clk_i) ack_i == stb_i)
        else begin
            $error("decoder ack does not follow the strobe");
            fail_cnt++;
        end

    a_unmapped_zero: assert property (@(posedge clk_i) (region_stb_i == '0) |-> (dat_i == '0))
        else begin
            $error("read data is not zero with no region selected");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: verif/peri_tb.sv
// Testbench for the peripheral subsystem with random bus traffic against a model
`default_nettype none

module peri_tb;

    localparam int PIPE_OPS  = 200;
    localparam int IRQ_OPS   = 64;
    localparam int LED_OPS   = 40;
    localparam int UNMAP_OPS = 40;
    localparam int TIM_POLLS = 60;
    localparam int DEPTH     = peri_map_pkg::COM_FIFO_DEPTH;
    // Bus accesses per test with a status read after each pipe op
    localparam int ACCESSES  = 2 * (2 * PIPE_OPS) + 2 * (2 * IRQ_OPS) + (TIM_POLLS + 6)
                               + 2 * LED_OPS + UNMAP_OPS + 8;
    localparam int TIMEOUT_CYCLES = ACCESSES * 4 + 4096;

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic [peri_bus_pkg::WB_ADR_WIDTH-1:0] adr;
    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_w;
    logic                                  we;
    logic [peri_bus_pkg::WB_SEL_WIDTH-1:0] sel;
    logic                                  stb;
    logic [peri_bus_pkg::WB_DAT_WIDTH-1:0] dat_r;
    logic                                  ack;
    logic [1:0]                            led;
    logic [peri_map_pkg::IRQ_NUM-1:0]      irq;

    // Model state
    integer      seed = 32'h5c36_afc8;
    logic [31:0] pipe_q [2][$];
    logic [1:0]  irq_en [2];        // Bit 1 rx, bit 0 tx
    logic        led_bit;
    logic [31:0] since_rst;
    int          cycle_cnt = 0;

    always #10 clk = ~clk;

    peri_top peri_top_i (
        .wb_peri_clk_i (clk),
        .wb_peri_rst_i (rst),
        .wb_peri_adr_i (adr),
        .wb_peri_dat_i (dat_w),
        .wb_peri_we_i  (we),
        .wb_peri_sel_i (sel),
        .wb_peri_stb_i (stb),
        .wb_peri_dat_o (dat_r),
        .wb_peri_ack_o (ack),
        .led_o         (led),
        .irq_o         (irq)
    );

    bind wb_addr_decode peri_asserts i_bus_asserts (
        .clk_i        (peri_tb.clk),
        .stb_i        (stb_i),
        .ack_i        (ack_o),
        .dat_i        (dat_o),
        .region_stb_i ({com0_o.stb, com1_o.stb, tim_o.stb, led_o.stb})
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("mismatch %s: expected %08h, actual %08h", name, exp_v, act_v);
            fail_run();
        end
    endtask

    function automatic logic [7:0] pipe_region(input int p);
        return (p == 0) ? peri_bus_pkg::REGION_COM0 : peri_bus_pkg::REGION_COM1;
    endfunction

    // One classic cycle that ends at the negedge after the write edge
    task automatic bus_access(input logic [7:0] region, input logic [1:0] ofs,
                              input logic write, input logic [31:0] wdata,
                              input logic [3:0] bytes, output logic [31:0] rdata);
        @(posedge clk);
        adr   <= {region, 14'd0, ofs};
        dat_w <= wdata;
        we    <= write;
        sel   <= bytes;
        stb   <= 1'b1;
        @(negedge clk);
        assert (ack === 1'b1) else begin
            $display("access to region %02h offset %0d was not acknowledged", region, ofs);
            fail_run();
        end
        rdata = dat_r;
        @(posedge clk);
        stb <= 1'b0;
        @(negedge clk);
    endtask

    task automatic pipe_op(input int p, input logic write, input string name);
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] exp_v;
        wdata = $random(seed);
        exp_v = '0;
        bus_access(pipe_region(p), peri_map_pkg::COM_REG_DATA, write, wdata, 4'hf, rdata);
        if (write) begin
            if (pipe_q[p].size() < DEPTH) begin
                pipe_q[p].push_back(wdata);     // Full pipe drops it
            end
        end else begin
            if (pipe_q[p].size() != 0) begin
                exp_v = pipe_q[p].pop_front();
            end
            check_value(name, exp_v, rdata);
        end
    endtask

    task automatic check_status(input int p, input string name);
        logic [31:0] rdata;
        logic [31:0] exp_v;
        exp_v = pipe_q[p].size();
        exp_v[peri_map_pkg::COM_STAT_FULL_BIT]  = (pipe_q[p].size() == DEPTH);
        exp_v[peri_map_pkg::COM_STAT_EMPTY_BIT] = (pipe_q[p].size() == 0);
        bus_access(pipe_region(p), peri_map_pkg::COM_REG_STATUS, 1'b0, '0, 4'hf, rdata);
        check_value(name, exp_v, rdata);
    endtask

    task automatic check_irq(input string name);
        logic [3:0] exp_v;
        exp_v[peri_map_pkg::IRQ_COM0_RX] = irq_en[0][1] && (pipe_q[0].size() != 0);
        exp_v[peri_map_pkg::IRQ_COM0_TX] = irq_en[0][0] && (pipe_q[0].size() < DEPTH);
        exp_v[peri_map_pkg::IRQ_COM1_RX] = irq_en[1][1] && (pipe_q[1].size() != 0);
        exp_v[peri_map_pkg::IRQ_COM1_TX] = irq_en[1][0] && (pipe_q[1].size() < DEPTH);
        check_value(name, 32'(exp_v), 32'(irq[3:0]));
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    task automatic pipe_order_test(input int p);
        logic [31:0] r;
        for (int i = 0; i < PIPE_OPS; i++) begin
            r = $random(seed);
            // Mostly writes first and mostly reads later
            pipe_op(p, (i < PIPE_OPS / 2) ? (r[3:0] < 4'd11) : (r[3:0] < 4'd5), "pipe order");
            check_status(p, "pipe status");
        end
    endtask

    task automatic pipe_irq_test(input int p);
        logic [31:0] r;
        logic [31:0] rdata;
        for (int i = 0; i < IRQ_OPS; i++) begin
            r = $random(seed);
            bus_access(pipe_region(p), peri_map_pkg::COM_REG_IRQEN, 1'b1, r, 4'hf, rdata);
            irq_en[p] = r[1:0];
            check_irq("irq after enable write");
            pipe_op(p, (i < IRQ_OPS / 2) ? (r[10:8] != 3'd0) : (r[10:8] == 3'd7), "irq data");
            check_irq("irq after data access");
        end
    endtask

    task automatic timer_test();
        logic [31:0] rdata;
        int          polls;
        bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_CMP, 1'b1, 32'd50, 4'hf, rdata);
        bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_CTL, 1'b1, 32'd1, 4'hf, rdata);
        bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_CMP, 1'b0, '0, 4'hf, rdata);
        check_value("timer compare", 32'd50, rdata);
        polls = 0;
        rdata = '0;
        while (rdata[0] == 1'b0) begin
            polls++;
            assert (polls <= TIM_POLLS) else begin
                $display("timer interrupt not set after %0d status polls", TIM_POLLS);
                fail_run();
            end
            bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_STAT, 1'b0, '0, 4'hf,
                       rdata);
        end
        check_value("timer irq set", 32'd1, 32'(irq[peri_map_pkg::IRQ_TIM]));
        bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_STAT, 1'b1, 32'd1, 4'hf, rdata);
        check_value("timer irq cleared", 32'd0, 32'(irq[peri_map_pkg::IRQ_TIM]));
        bus_access(peri_bus_pkg::REGION_TIM, peri_map_pkg::TIM_REG_CTL, 1'b1, 32'd0, 4'hf, rdata);
    endtask

    task automatic led_test();
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] rdata;
        for (int i = 0; i < LED_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            bus_access(peri_bus_pkg::REGION_LED, r[1:0], 1'b1, d, r[7:4], rdata);
            if (r[4]) begin
                led_bit = d[0];
            end
            check_value("led output", 32'(led_bit), 32'(led[0]));
            bus_access(peri_bus_pkg::REGION_LED, r[3:2], 1'b0, '0, 4'hf, rdata);
            check_value("led readback", 32'(led_bit), rdata);
        end
        repeat (2100) @(negedge clk);   // Let the heartbeat toggle
    endtask

    task automatic unmapped_test();
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] rdata;
        logic [7:0]  rgn;
        for (int i = 0; i < UNMAP_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            rgn = r[7:0];
            if (rgn == peri_bus_pkg::REGION_COM0 || rgn == peri_bus_pkg::REGION_COM1 ||
                rgn == peri_bus_pkg::REGION_TIM || rgn == peri_bus_pkg::REGION_LED) begin
                rgn = rgn ^ 8'h80;
            end
            bus_access(rgn, r[9:8], r[10], d, 4'hf, rdata);
            check_value("unmapped read data", '0, rdata);
        end
        for (int p = 0; p < 2; p++) begin
            check_status(p, "pipe state after unmapped");
            bus_access(pipe_region(p), peri_map_pkg::COM_REG_IRQEN, 1'b0, '0, 4'hf, rdata);
            check_value("irq enable after unmapped", 32'(irq_en[p]), rdata);
        end
        check_irq("irq after unmapped");
        bus_access(peri_bus_pkg::REGION_LED, 2'd0, 1'b0, '0, 4'hf, rdata);
        check_value("led after unmapped", 32'(led_bit), rdata);
    endtask

    // --------------------------------------------------
    // Watchers
    // --------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            since_rst <= '0;
        end else begin
            since_rst <= since_rst + 32'd1;
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            fail_run();
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            check_value("heartbeat", 32'(since_rst[peri_map_pkg::HEARTBEAT_BIT]), 32'(led[1]));
        end
        assert (peri_top_i.i_decode.i_bus_asserts.fail_cnt == 0) else begin
            $display("a bus protocol assertion fired in the address decoder");
            fail_run();
        end
    end

    initial begin
        rst       = 1'b1;
        adr       = '0;
        dat_w     = '0;
        we        = 1'b0;
        sel       = '0;
        stb       = 1'b0;
        led_bit   = 1'b0;
        irq_en[0] = 2'b00;
        irq_en[1] = 2'b00;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset irq", '0, 32'(irq));
        check_value("reset led", '0, 32'(led[0]));
        check_value("idle ack", '0, 32'(ack));
        pipe_order_test(0);
        pipe_order_test(1);
        pipe_irq_test(0);
        pipe_irq_test(1);
        timer_test();
        led_test();
        unmapped_test();
        @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
